// ==== design/soc_pkg.sv ====
package soc_pkg;

  // ====================
  // Bus widths
  // ====================
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;

  // ====================
  // Region map
  // ====================
  localparam logic [addr_w-1:0] tim_base   = 32'h0010_0000;
  localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
  localparam logic [addr_w-1:0] clint_size = 32'h0001_0000;
  localparam logic [addr_w-1:0] uart_base  = 32'h1000_0000;
  localparam logic [addr_w-1:0] uart_size  = 32'h0000_1000;

  // CLINT register offsets, high words at +4
  localparam logic [15:0] clint_msip_off     = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_off = 16'h4000;
  localparam logic [15:0] clint_mtime_off    = 16'hBFF8;

  typedef enum logic [1:0] {
    region_tim,
    region_clint,
    region_uart,
    region_none
  } region_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_ibus,
    arb_dbus
  } arb_state_t;

  // Byte-lane merge for strobed writes
  function automatic logic [data_w-1:0] merge_bytes(
    input logic [data_w-1:0] old_word,
    input logic [data_w-1:0] new_word,
    input logic [strb_w-1:0] strb
  );
    logic [data_w-1:0] result;
    result = old_word;
    for (int i = 0; i < strb_w; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import soc_pkg::*; #(
  parameter int TIM_DEPTH = 1024
) (
  input  logic              bus_valid,
  input  logic              bus_instr,
  input  logic [addr_w-1:0] bus_addr,
  input  logic [data_w-1:0] bus_wdata,
  input  logic [strb_w-1:0] bus_wstrb,
  output logic [data_w-1:0] bus_rdata,
  output logic              bus_ready,
  output logic              tim_valid,
  output logic              clint_valid,
  output logic              uart_valid,
  output logic              instr,
  output logic [addr_w-1:0] addr,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  input  logic [data_w-1:0] tim_rdata,
  input  logic              tim_ready,
  input  logic [data_w-1:0] clint_rdata,
  input  logic              clint_ready,
  input  logic [data_w-1:0] uart_rdata,
  input  logic              uart_ready
);

  localparam logic [addr_w-1:0] tim_top = tim_base + addr_w'(TIM_DEPTH * 4);

  region_t           region;
  logic [addr_w-1:0] base;

  // Address decode
  always_comb begin
    if (bus_addr >= tim_base && bus_addr < tim_top) begin
      region = region_tim;
    end else if (bus_addr >= clint_base && bus_addr < clint_base + clint_size) begin
      region = region_clint;
    end else if (bus_addr >= uart_base && bus_addr < uart_base + uart_size) begin
      region = region_uart;
    end else begin
      region = region_none;
    end
  end

  always_comb begin
    case (region)
      region_tim:   base = tim_base;
      region_clint: base = clint_base;
      region_uart:  base = uart_base;
      default:      base = '0;
    endcase
  end

  assign tim_valid   = bus_valid && (region == region_tim);
  assign clint_valid = bus_valid && (region == region_clint);
  assign uart_valid  = bus_valid && (region == region_uart);

  // Shared request fields, offset into the region
  assign addr  = bus_addr - base;
  assign instr = bus_instr;
  assign wdata = bus_wdata;
  assign wstrb = bus_wstrb;

  // Response mux, fixed priority
  always_comb begin
    if (tim_ready) begin
      bus_rdata = tim_rdata;
      bus_ready = 1'b1;
    end else if (clint_ready) begin
      bus_rdata = clint_rdata;
      bus_ready = 1'b1;
    end else if (uart_ready) begin
      bus_rdata = uart_rdata;
      bus_ready = 1'b1;
    end else begin
      bus_rdata = '0;
      bus_ready = 1'b0;
    end
  end

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import soc_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              ibus_valid,
  input  logic              ibus_instr,
  input  logic [addr_w-1:0] ibus_addr,
  input  logic [data_w-1:0] ibus_wdata,
  input  logic [strb_w-1:0] ibus_wstrb,
  output logic [data_w-1:0] ibus_rdata,
  output logic              ibus_ready,
  input  logic              dbus_valid,
  input  logic              dbus_instr,
  input  logic [addr_w-1:0] dbus_addr,
  input  logic [data_w-1:0] dbus_wdata,
  input  logic [strb_w-1:0] dbus_wstrb,
  output logic [data_w-1:0] dbus_rdata,
  output logic              dbus_ready,
  output logic              slave_valid,
  output logic              slave_instr,
  output logic [addr_w-1:0] slave_addr,
  output logic [data_w-1:0] slave_wdata,
  output logic [strb_w-1:0] slave_wstrb,
  input  logic [data_w-1:0] slave_rdata,
  input  logic              slave_ready
);

  arb_state_t state;
  arb_state_t state_next;

  // ====================
  // Grant FSM
  // ====================
  always_comb begin
    state_next = state;
    case (state)
      arb_idle: begin
        // dbus wins a tie
        if (dbus_valid) begin
          state_next = arb_dbus;
        end else if (ibus_valid) begin
          state_next = arb_ibus;
        end
      end
      arb_ibus, arb_dbus: begin
        if (slave_ready) begin
          state_next = arb_idle;
        end
      end
      default: state_next = arb_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= arb_idle;
    end else begin
      state <= state_next;
    end
  end

  // ====================
  // Request forwarding
  // ====================
  always_comb begin
    case (state)
      arb_ibus: begin
        slave_valid = ibus_valid;
        slave_instr = ibus_instr;
        slave_addr  = ibus_addr;
        slave_wdata = ibus_wdata;
        slave_wstrb = ibus_wstrb;
      end
      arb_dbus: begin
        slave_valid = dbus_valid;
        slave_instr = dbus_instr;
        slave_addr  = dbus_addr;
        slave_wdata = dbus_wdata;
        slave_wstrb = dbus_wstrb;
      end
      default: begin
        slave_valid = 1'b0;
        slave_instr = 1'b0;
        slave_addr  = '0;
        slave_wdata = '0;
        slave_wstrb = '0;
      end
    endcase
  end

  // Response goes back to the granted master only
  assign ibus_ready = (state == arb_ibus) && slave_ready;
  assign dbus_ready = (state == arb_dbus) && slave_ready;
  assign ibus_rdata = (state == arb_ibus) ? slave_rdata : '0;
  assign dbus_rdata = (state == arb_dbus) ? slave_rdata : '0;

endmodule

// ==== design/tim_memory.sv ====
`timescale 1ns/1ps

module tim_memory import soc_pkg::*; #(
  parameter int TIM_DEPTH = 1024
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              valid,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  output logic [data_w-1:0] rdata,
  output logic              ready
);

  localparam int idx_w = $clog2(TIM_DEPTH);

  logic [data_w-1:0] mem [TIM_DEPTH];
  logic [idx_w-1:0]  idx;
  logic              access;

  // Word index from the byte offset
  assign idx = addr[idx_w+1:2];

  // One access per request, ready blocks a repeat
  assign access = valid && !ready;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  // ====================
  // Storage
  // ====================
  always_ff @(posedge clock) begin
    if (access) begin
      if (wstrb != '0) begin
        mem[idx] <= merge_bytes(mem[idx], wdata, wstrb);
      end
      rdata <= mem[idx];
    end
  end

endmodule

// ==== design/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer import soc_pkg::*; (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              valid,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  output logic [data_w-1:0] rdata,
  output logic              ready,
  output logic              msip,
  output logic              mtip,
  output logic [63:0]       mtime
);

  logic [15:0]       off;
  logic              access;
  logic              write;
  logic [63:0]       mtimecmp;
  logic [data_w-1:0] read_word;

  assign off    = addr[15:0];
  assign access = valid && !ready;
  assign write  = access && (wstrb != '0);

  // ====================
  // Register block
  // ====================
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ready    <= 1'b0;
      msip     <= 1'b0;
      mtimecmp <= '1;
    end else begin
      ready <= access;
      if (write) begin
        case (off)
          clint_msip_off: begin
            if (wstrb[0]) begin
              msip <= wdata[0];
            end
          end
          clint_mtimecmp_off:
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
          clint_mtimecmp_off + 16'd4:
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (off)
      clint_msip_off:             read_word = data_w'(msip);
      clint_mtimecmp_off:         read_word = mtimecmp[31:0];
      clint_mtimecmp_off + 16'd4: read_word = mtimecmp[63:32];
      clint_mtime_off:            read_word = mtime[31:0];
      clint_mtime_off + 16'd4:    read_word = mtime[63:32];
      default:                    read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (access) begin
      rdata <= read_word;
    end
  end

  // ====================
  // Timer and compare
  // ====================
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (write && off == clint_mtime_off) begin
      mtime[31:0] <= merge_bytes(mtime[31:0], wdata, wstrb);
    end else if (write && off == clint_mtime_off + 16'd4) begin
      mtime[63:32] <= merge_bytes(mtime[63:32], wdata, wstrb);
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign mtip = (mtime >= mtimecmp);

endmodule

// ==== design/soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric import soc_pkg::*; #(
  parameter int TIM_DEPTH = 1024
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              ibus_valid,
  input  logic              ibus_instr,
  input  logic [addr_w-1:0] ibus_addr,
  input  logic [data_w-1:0] ibus_wdata,
  input  logic [strb_w-1:0] ibus_wstrb,
  output logic [data_w-1:0] ibus_rdata,
  output logic              ibus_ready,
  input  logic              dbus_valid,
  input  logic              dbus_instr,
  input  logic [addr_w-1:0] dbus_addr,
  input  logic [data_w-1:0] dbus_wdata,
  input  logic [strb_w-1:0] dbus_wstrb,
  output logic [data_w-1:0] dbus_rdata,
  output logic              dbus_ready,
  output logic              uart_valid,
  output logic              uart_instr,
  output logic [addr_w-1:0] uart_addr,
  output logic [data_w-1:0] uart_wdata,
  output logic [strb_w-1:0] uart_wstrb,
  input  logic [data_w-1:0] uart_rdata,
  input  logic              uart_ready,
  output logic              msip,
  output logic              mtip,
  output logic [63:0]       mtime
);

  // Decoded request fields, shared by all regions of one bus
  logic              ibus_req_instr, dbus_req_instr;
  logic [addr_w-1:0] ibus_req_addr, dbus_req_addr;
  logic [data_w-1:0] ibus_req_wdata, dbus_req_wdata;
  logic [strb_w-1:0] ibus_req_wstrb, dbus_req_wstrb;

  // Per-region links
  logic              itim_valid, dtim_valid, iclint_valid, dclint_valid;
  logic              iuart_valid, duart_valid;
  logic [data_w-1:0] itim_rdata, dtim_rdata, iclint_rdata, dclint_rdata;
  logic [data_w-1:0] iuart_rdata, duart_rdata;
  logic              itim_ready, dtim_ready, iclint_ready, dclint_ready;
  logic              iuart_ready, duart_ready;

  // Slave side
  logic              tim_valid, clint_valid;
  logic [addr_w-1:0] tim_addr, clint_addr;
  logic [data_w-1:0] tim_wdata, clint_wdata, tim_rdata, clint_rdata;
  logic [strb_w-1:0] tim_wstrb, clint_wstrb;
  logic              tim_ready, clint_ready;

  // ====================
  // Decoders
  // ====================
  bus_decoder #(.TIM_DEPTH(TIM_DEPTH)) u_ibus_decoder (
    .bus_valid(ibus_valid), .bus_instr(ibus_instr), .bus_addr(ibus_addr),
    .bus_wdata(ibus_wdata), .bus_wstrb(ibus_wstrb),
    .bus_rdata(ibus_rdata), .bus_ready(ibus_ready),
    .tim_valid(itim_valid), .clint_valid(iclint_valid), .uart_valid(iuart_valid),
    .instr(ibus_req_instr), .addr(ibus_req_addr),
    .wdata(ibus_req_wdata), .wstrb(ibus_req_wstrb),
    .tim_rdata(itim_rdata), .tim_ready(itim_ready),
    .clint_rdata(iclint_rdata), .clint_ready(iclint_ready),
    .uart_rdata(iuart_rdata), .uart_ready(iuart_ready)
  );

  bus_decoder #(.TIM_DEPTH(TIM_DEPTH)) u_dbus_decoder (
    .bus_valid(dbus_valid), .bus_instr(dbus_instr), .bus_addr(dbus_addr),
    .bus_wdata(dbus_wdata), .bus_wstrb(dbus_wstrb),
    .bus_rdata(dbus_rdata), .bus_ready(dbus_ready),
    .tim_valid(dtim_valid), .clint_valid(dclint_valid), .uart_valid(duart_valid),
    .instr(dbus_req_instr), .addr(dbus_req_addr),
    .wdata(dbus_req_wdata), .wstrb(dbus_req_wstrb),
    .tim_rdata(dtim_rdata), .tim_ready(dtim_ready),
    .clint_rdata(dclint_rdata), .clint_ready(dclint_ready),
    .uart_rdata(duart_rdata), .uart_ready(duart_ready)
  );

  // ====================
  // Arbiters
  // ====================
  bus_arbiter u_tim_arbiter (
    .clock(clock), .rst_n(rst_n),
    .ibus_valid(itim_valid), .ibus_instr(ibus_req_instr), .ibus_addr(ibus_req_addr),
    .ibus_wdata(ibus_req_wdata), .ibus_wstrb(ibus_req_wstrb),
    .ibus_rdata(itim_rdata), .ibus_ready(itim_ready),
    .dbus_valid(dtim_valid), .dbus_instr(dbus_req_instr), .dbus_addr(dbus_req_addr),
    .dbus_wdata(dbus_req_wdata), .dbus_wstrb(dbus_req_wstrb),
    .dbus_rdata(dtim_rdata), .dbus_ready(dtim_ready),
    .slave_valid(tim_valid), .slave_instr(), .slave_addr(tim_addr),
    .slave_wdata(tim_wdata), .slave_wstrb(tim_wstrb),
    .slave_rdata(tim_rdata), .slave_ready(tim_ready)
  );

  bus_arbiter u_clint_arbiter (
    .clock(clock), .rst_n(rst_n),
    .ibus_valid(iclint_valid), .ibus_instr(ibus_req_instr), .ibus_addr(ibus_req_addr),
    .ibus_wdata(ibus_req_wdata), .ibus_wstrb(ibus_req_wstrb),
    .ibus_rdata(iclint_rdata), .ibus_ready(iclint_ready),
    .dbus_valid(dclint_valid), .dbus_instr(dbus_req_instr), .dbus_addr(dbus_req_addr),
    .dbus_wdata(dbus_req_wdata), .dbus_wstrb(dbus_req_wstrb),
    .dbus_rdata(dclint_rdata), .dbus_ready(dclint_ready),
    .slave_valid(clint_valid), .slave_instr(), .slave_addr(clint_addr),
    .slave_wdata(clint_wdata), .slave_wstrb(clint_wstrb),
    .slave_rdata(clint_rdata), .slave_ready(clint_ready)
  );

  // UART slave lives outside the fabric
  bus_arbiter u_uart_arbiter (
    .clock(clock), .rst_n(rst_n),
    .ibus_valid(iuart_valid), .ibus_instr(ibus_req_instr), .ibus_addr(ibus_req_addr),
    .ibus_wdata(ibus_req_wdata), .ibus_wstrb(ibus_req_wstrb),
    .ibus_rdata(iuart_rdata), .ibus_ready(iuart_ready),
    .dbus_valid(duart_valid), .dbus_instr(dbus_req_instr), .dbus_addr(dbus_req_addr),
    .dbus_wdata(dbus_req_wdata), .dbus_wstrb(dbus_req_wstrb),
    .dbus_rdata(duart_rdata), .dbus_ready(duart_ready),
    .slave_valid(uart_valid), .slave_instr(uart_instr), .slave_addr(uart_addr),
    .slave_wdata(uart_wdata), .slave_wstrb(uart_wstrb),
    .slave_rdata(uart_rdata), .slave_ready(uart_ready)
  );

  // ====================
  // Slaves
  // ====================
  tim_memory #(.TIM_DEPTH(TIM_DEPTH)) u_tim_memory (
    .clock(clock), .rst_n(rst_n),
    .valid(tim_valid), .addr(tim_addr), .wdata(tim_wdata), .wstrb(tim_wstrb),
    .rdata(tim_rdata), .ready(tim_ready)
  );

  clint_timer u_clint_timer (
    .clock(clock), .rst_n(rst_n),
    .valid(clint_valid), .addr(clint_addr), .wdata(clint_wdata), .wstrb(clint_wstrb),
    .rdata(clint_rdata), .ready(clint_ready),
    .msip(msip), .mtip(mtip), .mtime(mtime)
  );

endmodule

// ==== bench/soc_fabric_checker.sv ====
`timescale 1ns/1ps

module soc_fabric_checker import soc_pkg::*; (
  input logic       clock,
  input logic       rst_n,
  input arb_state_t state,
  input logic       ibus_valid,
  input logic       dbus_valid,
  input logic       ibus_ready,
  input logic       dbus_ready,
  input logic       slave_valid
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  a_single_ready: assert property (@(posedge clock) disable iff (!rst_n)
    !(ibus_ready && dbus_ready))
    else begin
      fail_count++;
      $error("ibus_ready and dbus_ready high in the same cycle");
    end

  a_ibus_ready_valid: assert property (@(posedge clock) disable iff (!rst_n)
    ibus_ready |-> ibus_valid)
    else begin
      fail_count++;
      $error("ibus_ready without ibus_valid");
    end

  a_dbus_ready_valid: assert property (@(posedge clock) disable iff (!rst_n)
    dbus_ready |-> dbus_valid)
    else begin
      fail_count++;
      $error("dbus_ready without dbus_valid");
    end

  // No request reaches the slave before a grant
  a_idle_quiet: assert property (@(posedge clock) disable iff (!rst_n)
    (state == arb_idle) |-> !slave_valid)
    else begin
      fail_count++;
      $error("slave_valid high while the arbiter is idle");
    end

endmodule

bind bus_arbiter soc_fabric_checker u_checker (
  .clock(clock),
  .rst_n(rst_n),
  .state(state),
  .ibus_valid(ibus_valid),
  .dbus_valid(dbus_valid),
  .ibus_ready(ibus_ready),
  .dbus_ready(dbus_ready),
  .slave_valid(slave_valid)
);

// ==== bench/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb;

  localparam int          ready_timeout  = 50;
  localparam int          valid_timeout  = 50;
  localparam logic [31:0] uart_base_addr = 32'h1000_0000;
  localparam logic [31:0] uart_rule_key  = 32'hA5A5_0000;

  logic        clock;
  logic        rst_n;
  logic        ibus_valid;
  logic        ibus_instr;
  logic [31:0] ibus_addr;
  logic [31:0] ibus_wdata;
  logic [3:0]  ibus_wstrb;
  logic [31:0] ibus_rdata;
  logic        ibus_ready;
  logic        dbus_valid;
  logic        dbus_instr;
  logic [31:0] dbus_addr;
  logic [31:0] dbus_wdata;
  logic [3:0]  dbus_wstrb;
  logic [31:0] dbus_rdata;
  logic        dbus_ready;
  logic        uart_valid;
  logic        uart_instr;
  logic [31:0] uart_addr;
  logic [31:0] uart_wdata;
  logic [3:0]  uart_wstrb;
  logic [31:0] uart_rdata;
  logic        uart_ready;
  logic        msip;
  logic        mtip;
  logic [63:0] mtime;

  int cycle_count = 0;
  int seed = 53;

  soc_fabric i_soc_fabric (
    .clock(clock), .rst_n(rst_n),
    .ibus_valid(ibus_valid), .ibus_instr(ibus_instr), .ibus_addr(ibus_addr),
    .ibus_wdata(ibus_wdata), .ibus_wstrb(ibus_wstrb),
    .ibus_rdata(ibus_rdata), .ibus_ready(ibus_ready),
    .dbus_valid(dbus_valid), .dbus_instr(dbus_instr), .dbus_addr(dbus_addr),
    .dbus_wdata(dbus_wdata), .dbus_wstrb(dbus_wstrb),
    .dbus_rdata(dbus_rdata), .dbus_ready(dbus_ready),
    .uart_valid(uart_valid), .uart_instr(uart_instr), .uart_addr(uart_addr),
    .uart_wdata(uart_wdata), .uart_wstrb(uart_wstrb),
    .uart_rdata(uart_rdata), .uart_ready(uart_ready),
    .msip(msip), .mtip(mtip), .mtime(mtime)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s actual=0x%08h expected=0x%08h", name, actual, expected));
    end
  endtask

  // One request on ibus or dbus, held until its ready
  task automatic bus_access(input bit use_dbus, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata, output int done_cycle);
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    @(posedge clock);
    #1;
    if (use_dbus) begin
      dbus_valid = 1'b1;
      dbus_instr = 1'b0;
      dbus_addr  = addr;
      dbus_wdata = wdata;
      dbus_wstrb = wstrb;
    end else begin
      ibus_valid = 1'b1;
      ibus_instr = 1'b1;
      ibus_addr  = addr;
      ibus_wdata = wdata;
      ibus_wstrb = wstrb;
    end
    while (!seen) begin
      @(negedge clock);
      seen = use_dbus ? dbus_ready : ibus_ready;
      waited++;
      if (!seen && waited > ready_timeout) begin
        fail_run(use_dbus ? "timeout waiting for dbus_ready" : "timeout waiting for ibus_ready");
      end
    end
    rdata = use_dbus ? dbus_rdata : ibus_rdata;
    done_cycle = cycle_count;
    @(posedge clock);
    #1;
    if (use_dbus) begin
      dbus_valid = 1'b0;
      dbus_wstrb = 4'h0;
    end else begin
      ibus_valid = 1'b0;
      ibus_wstrb = 4'h0;
    end
  endtask

  // UART slave model, answers after a random delay
  task automatic serve_uart(input logic [31:0] exp_addr, input logic exp_instr,
                            input logic [31:0] exp_wdata, input logic [3:0] exp_wstrb);
    int waited;
    int delay;
    waited = 0;
    while (!uart_valid) begin
      @(negedge clock);
      waited++;
      if (!uart_valid && waited > valid_timeout) begin
        fail_run("timeout waiting for uart_valid");
      end
    end
    check_value("uart_addr", uart_addr, exp_addr);
    check_value("uart_instr", 32'(uart_instr), 32'(exp_instr));
    check_value("uart_wdata", uart_wdata, exp_wdata);
    check_value("uart_wstrb", 32'(uart_wstrb), 32'(exp_wstrb));
    delay = $unsigned($random(seed)) % 6;
    repeat (delay) @(posedge clock);
    @(posedge clock);
    #1;
    uart_rdata = uart_addr ^ uart_rule_key;
    uart_ready = 1'b1;
    @(posedge clock);
    #1;
    uart_ready = 1'b0;
    uart_rdata = 32'h0;
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = 0;
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic run_vector(input byte port_ch, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input logic [31:0] expected, input int dont_care);
    logic [31:0] i_rd;
    logic [31:0] d_rd;
    int          i_cycle;
    int          d_cycle;
    bit          use_dbus;
    use_dbus = (port_ch == "d");
    if (port_ch == "b") begin
      fork
        bus_access(1'b0, addr, wdata, wstrb, i_rd, i_cycle);
        bus_access(1'b1, addr, wdata, wstrb, d_rd, d_cycle);
      join
      check_value("ibus_rdata", i_rd, expected);
      check_value("dbus_rdata", d_rd, expected);
      if (d_cycle >= i_cycle) begin
        fail_run("dbus_ready did not come before ibus_ready on a contended access");
      end
    end else if (addr[31:12] == uart_base_addr[31:12]) begin
      fork
        bus_access(use_dbus, addr, wdata, wstrb, d_rd, d_cycle);
        serve_uart(addr - uart_base_addr, !use_dbus, wdata, wstrb);
      join
      check_value(use_dbus ? "dbus_rdata" : "ibus_rdata", d_rd, expected);
    end else begin
      bus_access(use_dbus, addr, wdata, wstrb, d_rd, d_cycle);
      if (dont_care == 0) begin
        check_value(use_dbus ? "dbus_rdata" : "ibus_rdata", d_rd, expected);
      end
    end
  endtask

  initial begin
    int          fd;
    int          c;
    int          code;
    int          dont_care;
    int          vector_count;
    int          waited;
    int          cyc;
    int          assert_failures;
    byte         port_ch;
    bit          done;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expected;
    logic [31:0] rd;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [3:0]  wstrb;

    rst_n = 1'b0;
    ibus_valid = 1'b0;
    ibus_instr = 1'b0;
    ibus_addr = 32'h0;
    ibus_wdata = 32'h0;
    ibus_wstrb = 4'h0;
    dbus_valid = 1'b0;
    dbus_instr = 1'b0;
    dbus_addr = 32'h0;
    dbus_wdata = 32'h0;
    dbus_wstrb = 4'h0;
    uart_rdata = 32'h0;
    uart_ready = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    rst_n = 1'b1;
    @(negedge clock);
    check_value("mtip", 32'(mtip), 32'h0);
    check_value("msip", 32'(msip), 32'h0);

    // ====================
    // Vector file
    // ====================
    fd = $fopen("bench/soc_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("could not open bench/soc_vectors.txt");
    end
    done = 1'b0;
    vector_count = 0;
    while (!done) begin
      c = $fgetc(fd);
      port_ch = byte'(c);
      if (c == -1) begin
        done = 1'b1;
      end else if (port_ch == "#") begin
        skip_line(fd);
      end else if (port_ch == "i" || port_ch == "d" || port_ch == "b") begin
        code = $fscanf(fd, "%h %h %h %h %d", addr, wdata, wstrb, expected, dont_care);
        if (code != 5) begin
          fail_run("malformed line in the vector file");
        end
        run_vector(port_ch, addr, wdata, wstrb, expected, dont_care);
        vector_count++;
      end
    end
    $fclose(fd);
    if (vector_count == 0) begin
      fail_run("the vector file held no vectors");
    end

    // ====================
    // CLINT
    // ====================
    bus_access(1'b1, 32'h0200_0000, 32'h1, 4'h1, rd, cyc);
    check_value("msip", 32'(msip), 32'h1);
    bus_access(1'b0, 32'h0200_0000, 32'h0, 4'h0, rd, cyc);
    check_value("ibus_rdata", rd, 32'h1);
    bus_access(1'b1, 32'h0200_0000, 32'h0, 4'h1, rd, cyc);
    check_value("msip", 32'(msip), 32'h0);

    bus_access(1'b1, 32'h0200_BFF8, 32'h0, 4'h0, t0, cyc);
    bus_access(1'b1, 32'h0200_BFF8, 32'h0, 4'h0, t1, cyc);
    if (t1 <= t0) begin
      fail_run("mtime did not advance between two reads");
    end
    // Timer port keeps running past the last bus read
    check_value("mtime[63:32]", mtime[63:32], 32'h0);
    if ((mtime[31:0] > t1) !== 1'b1) begin
      fail_run("mtime output is not ahead of the value read over the bus");
    end
    check_value("mtip", 32'(mtip), 32'h0);

    // Compare value already behind mtime
    bus_access(1'b1, 32'h0200_4000, t1, 4'hF, rd, cyc);
    bus_access(1'b1, 32'h0200_4004, 32'h0, 4'hF, rd, cyc);
    waited = 0;
    while (!mtip) begin
      @(negedge clock);
      waited++;
      if (!mtip && waited > ready_timeout) begin
        fail_run("mtip did not rise after mtimecmp was set below mtime");
      end
    end
    bus_access(1'b1, 32'h0200_4004, 32'hFFFF_FFFF, 4'hF, rd, cyc);
    bus_access(1'b1, 32'h0200_4000, 32'hFFFF_FFFF, 4'hF, rd, cyc);
    check_value("mtip", 32'(mtip), 32'h0);

    assert_failures = i_soc_fabric.u_tim_arbiter.u_checker.fail_count
                    + i_soc_fabric.u_clint_arbiter.u_checker.fail_count
                    + i_soc_fabric.u_uart_arbiter.u_checker.fail_count;
    if (assert_failures == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run("arbiter assertions failed during the run");
    end
  end

endmodule

// ==== bench/soc_vectors.txt ====
# port addr wdata wstrb expected_rdata dont_care, all hex except dont_care
# port i = ibus, d = dbus, b = same read on both buses at once; dont_care 1 skips rdata
d 00100000 11223344 f 00000000 1
d 00100000 aabbccdd 3 00000000 1
i 00100000 00000000 0 1122ccdd 0
d 00100000 00000000 0 1122ccdd 0
i 00100004 deadbeef f 00000000 1
d 00100004 00550000 4 00000000 1
i 00100004 00000000 0 de55beef 0
d 00100004 00000000 0 de55beef 0
d 00100008 cafef00d f 00000000 1
i 00100008 00000012 1 00000000 1
d 00100008 77000000 8 00000000 1
i 00100008 00000000 0 77fef012 0
d 00100ffc 01020304 f 00000000 1
d 00100ffc 99000000 c 00000000 1
i 00100ffc 00000000 0 99000304 0
b 00100000 00000000 0 1122ccdd 0
b 00100008 00000000 0 77fef012 0
b 00100ffc 00000000 0 99000304 0
d 10000010 00000000 0 a5a50010 0
i 10000024 00000000 0 a5a50024 0
d 10000008 12345678 f a5a50008 0
i 10000ffc 0badf00d 3 a5a50ffc 0
d 10000000 00000000 0 a5a50000 0

// ==== verilog.f ====
design/soc_pkg.sv
design/bus_decoder.sv
design/bus_arbiter.sv
design/tim_memory.sv
design/clint_timer.sv
design/soc_fabric.sv
bench/soc_fabric_checker.sv
bench/soc_fabric_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the soc_fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -f verilog.f \
    --top-module soc_fabric_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vsoc_fabric_tb +verilator+error+limit+100 > "$log_file" 2>&1; then
  cat "$log_file"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$log_file"

if grep -q "RESULT: PASS" "$log_file"; then
  exit 0
fi
echo "Pass line not found in $log_file"
exit 1
